// ==== Makefile ====
TOP = cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cpu_top.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -Wall --top-module cpu_top -f cpu_top.f

clean:
	rm -rf obj_dir

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;

    // Operation byte at the start of each instruction.
    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_MOVI  = 8'h01,
        OP_ADD   = 8'h02,
        OP_SUB   = 8'h03,
        OP_OUT   = 8'h04,
        OP_JMP   = 8'h05,
        OP_SETIV = 8'h06,
        OP_EI    = 8'h07,
        OP_IRET  = 8'h08,
        OP_HALT  = 8'h09
    } opcode_e;

    // Register 0 is IP, registers 1 to 7 are A to G.
    typedef logic [2:0] reg_idx_t;
    localparam reg_idx_t REG_IP = 3'd0;
    localparam reg_idx_t REG_A = 3'd1;

    typedef enum logic [2:0] {
        FETCH_OPERATION,
        FETCH_OPERAND1,
        FETCH_OPERAND2,
        EXECUTE,
        RUN_INTERRUPT,
        ADD_INTERRUPTS,
        HALTED
    } cpu_state_e;

    // One operation byte and two four-byte operands.
    localparam word_t INSTR_BYTES = 32'd9;
    localparam int OPERAND_BYTES = 4;

    typedef struct packed {
        byte_t irq_type;
        word_t value;
    } irq_entry_t;

    localparam byte_t IRQ_TYPE_KEY = 8'd0;
    localparam int NUM_IRQ = 4;
    typedef logic [$clog2(NUM_IRQ)-1:0] vec_idx_t;

endpackage

// ==== control/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
    import cpu_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 10
)
(
    input  logic                     CLOCK_50,
    input  logic                     rst_i,
    input  logic                     run_i,
    output logic [MEM_ADDR_BITS-1:0] fetch_addr_o,
    input  byte_t                    fetch_data_i,
    output reg_idx_t                 rd_idx_a_o,
    output reg_idx_t                 rd_idx_b_o,
    input  word_t                    rd_data_a_i,
    input  word_t                    rd_data_b_i,
    input  word_t                    ip_i,
    output logic                     wr_en_o,
    output reg_idx_t                 wr_idx_o,
    output word_t                    wr_data_o,
    output logic                     ip_wr_en_o,
    output word_t                    ip_wr_data_o,
    output logic                     save_o,
    output logic                     restore_o,
    output opcode_e                  alu_op_o,
    output word_t                    alu_a_o,
    output word_t                    alu_b_o,
    input  word_t                    alu_result_i,
    output logic                     key_enable_o,
    input  logic                     key_pending_i,
    output logic                     key_pop_o,
    input  logic                     irq_pending_i,
    output logic                     irq_pop_o,
    input  word_t                    irq_value_i,
    input  word_t                    irq_vector_i,
    output logic                     vec_we_o,
    output vec_idx_t                 vec_idx_o,
    output word_t                    vec_addr_o,
    output logic                     out_valid_o,
    output word_t                    out_data_o,
    output logic                     halted_o
);

    localparam int CNT_BITS = $clog2(OPERAND_BYTES);

    // Interrupt entry steps: check and pop, wait for FIFO data, enter the ISR.
    localparam logic [1:0] IRQ_CHECK = 2'd0;
    localparam logic [1:0] IRQ_WAIT = 2'd1;
    localparam logic [1:0] IRQ_ENTER = 2'd2;

    cpu_state_e state;
    logic rd_wait;
    logic [CNT_BITS-1:0] byte_cnt;
    logic [1:0] irq_step;
    logic ie;
    logic irq_running;

    opcode_e operation;
    word_t operand1;
    word_t operand2;
    logic [3:0] byte_off;

    logic executing;
    logic irq_entry;
    logic writes_reg;

    // Byte offset inside the instruction for the current fetch.
    always_comb
    begin
        case (state)
            FETCH_OPERAND1: byte_off = 4'd1 + 4'(byte_cnt);
            FETCH_OPERAND2: byte_off = 4'(1 + OPERAND_BYTES) + 4'(byte_cnt);
            default:        byte_off = 4'd0;
        endcase
    end

    assign fetch_addr_o = ip_i[MEM_ADDR_BITS-1:0] + MEM_ADDR_BITS'(byte_off);

    assign executing = (state == EXECUTE);
    assign irq_entry = (state == RUN_INTERRUPT) && (irq_step == IRQ_ENTER);
    assign writes_reg = operation inside {OP_MOVI, OP_ADD, OP_SUB};

    // Operand1 names the first register, operand2 the second or an immediate.
    assign rd_idx_a_o = reg_idx_t'(operand1);
    assign rd_idx_b_o = reg_idx_t'(operand2);
    assign alu_op_o = operation;
    assign alu_a_o = rd_data_a_i;
    assign alu_b_o = (operation == OP_MOVI) ? operand2 : rd_data_b_i;

    // Interrupt entry writes the value into A.
    assign wr_en_o = (executing && writes_reg) || irq_entry;
    assign wr_idx_o = irq_entry ? REG_A : reg_idx_t'(operand1);
    assign wr_data_o = irq_entry ? irq_value_i : alu_result_i;

    // IRET takes IP from the shadow set and HALT leaves it in place.
    assign ip_wr_en_o = irq_entry || (executing && !(operation inside {OP_IRET, OP_HALT}));

    always_comb
    begin
        if (irq_entry)
            ip_wr_data_o = irq_vector_i;
        else if (operation == OP_JMP)
            ip_wr_data_o = operand2;
        else
            ip_wr_data_o = ip_i + INSTR_BYTES;
    end

    assign save_o = irq_entry;
    assign restore_o = executing && (operation == OP_IRET);

    assign vec_we_o = executing && (operation == OP_SETIV);
    assign vec_idx_o = vec_idx_t'(operand1);
    assign vec_addr_o = operand2;

    assign irq_pop_o = (state == RUN_INTERRUPT) && (irq_step == IRQ_CHECK)
                       && !irq_running && irq_pending_i;
    assign key_pop_o = (state == ADD_INTERRUPTS) && ie && key_pending_i;
    assign key_enable_o = ie;
    assign halted_o = (state == HALTED);

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            state <= FETCH_OPERATION;
            rd_wait <= 1'b0;
            byte_cnt <= '0;
            irq_step <= IRQ_CHECK;
            ie <= 1'b0;
            irq_running <= 1'b0;
            out_valid_o <= 1'b0;
        end
        else
        begin
            out_valid_o <= 1'b0;
            case (state)
                FETCH_OPERATION:
                begin
                    // Idle at IP 0 until run_i rises.
                    if (rd_wait)
                    begin
                        rd_wait <= 1'b0;
                        state <= FETCH_OPERAND1;
                    end
                    else if (run_i)
                    begin
                        rd_wait <= 1'b1;
                    end
                end
                FETCH_OPERAND1, FETCH_OPERAND2:
                begin
                    rd_wait <= !rd_wait;
                    if (rd_wait)
                    begin
                        if (byte_cnt == CNT_BITS'(OPERAND_BYTES - 1))
                        begin
                            byte_cnt <= '0;
                            state <= (state == FETCH_OPERAND1) ? FETCH_OPERAND2 : EXECUTE;
                        end
                        else
                        begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                EXECUTE:
                begin
                    if (operation == OP_OUT)
                        out_valid_o <= 1'b1;
                    if (operation == OP_EI)
                        ie <= 1'b1;
                    if (operation == OP_IRET)
                        irq_running <= 1'b0;
                    state <= (operation == OP_HALT) ? HALTED : RUN_INTERRUPT;
                end
                RUN_INTERRUPT:
                begin
                    case (irq_step)
                        IRQ_CHECK:
                        begin
                            if (!irq_running && irq_pending_i)
                                irq_step <= IRQ_WAIT;
                            else
                                state <= ADD_INTERRUPTS;
                        end
                        IRQ_WAIT:
                        begin
                            irq_step <= IRQ_ENTER;
                        end
                        default:
                        begin
                            irq_running <= 1'b1;
                            irq_step <= IRQ_CHECK;
                            state <= ADD_INTERRUPTS;
                        end
                    endcase
                end
                ADD_INTERRUPTS:
                begin
                    // At most one scancode per instruction, popped above.
                    state <= FETCH_OPERATION;
                end
                default:
                begin
                    state <= HALTED;
                end
            endcase
        end
    end

    // The instruction bytes shift in from the top, low byte first.
    always_ff @(posedge CLOCK_50)
    begin
        if (rd_wait)
        begin
            if (state == FETCH_OPERATION)
                operation <= opcode_e'(fetch_data_i);
            else if (state == FETCH_OPERAND1)
                operand1 <= {fetch_data_i, operand1[31:8]};
            else if (state == FETCH_OPERAND2)
                operand2 <= {fetch_data_i, operand2[31:8]};
        end
        if (executing && (operation == OP_OUT))
            out_data_o <= rd_data_a_i;
    end

endmodule

// ==== cpu_top.f ====
common/cpu_pkg.sv
logic/sync_fifo.sv
logic/alu.sv
logic/register_file.sv
logic/program_memory.sv
interrupt/interrupt_controller.sv
control/cpu_control.sv
logic/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// ==== interrupt/interrupt_controller.sv ====
`timescale 1ns/1ps

module interrupt_controller
    import cpu_pkg::*;
#(
    parameter int KEY_FIFO_DEPTH = 5,
    parameter int IRQ_FIFO_DEPTH = 10
)
(
    input  logic     CLOCK_50,
    input  logic     rst_i,
    input  logic     key_valid_i,
    input  byte_t    key_code_i,
    input  logic     key_enable_i,
    input  logic     key_pop_i,
    output logic     key_pending_o,
    input  logic     irq_pop_i,
    output logic     irq_pending_o,
    output word_t    irq_value_o,
    output word_t    irq_vector_o,
    input  logic     vec_we_i,
    input  vec_idx_t vec_idx_i,
    input  word_t    vec_addr_i
);

    byte_t key_head;
    logic key_push;
    logic key_empty;
    logic key_full;
    logic key_pop_q;

    irq_entry_t irq_push_data;
    irq_entry_t irq_head;
    logic irq_empty;
    logic irq_full;

    word_t vec_table [NUM_IRQ];

    // Keys pressed with interrupts off are dropped here.
    assign key_push = key_valid_i && key_enable_i && !key_full;

    sync_fifo #(
        .item_t(byte_t),
        .DEPTH (KEY_FIFO_DEPTH)
    ) key_fifo (
        .CLOCK_50   (CLOCK_50),
        .rst_i      (rst_i),
        .push_i     (key_push),
        .push_data_i(key_code_i),
        .pop_i      (key_pop_i),
        .pop_data_o (key_head),
        .empty_o    (key_empty),
        .full_o     (key_full)
    );

    // The popped scancode is out one cycle later and becomes a KEY entry then.
    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
            key_pop_q <= 1'b0;
        else
            key_pop_q <= key_pop_i && !key_empty;
    end

    assign irq_push_data = '{irq_type: IRQ_TYPE_KEY, value: word_t'(key_head)};

    sync_fifo #(
        .item_t(irq_entry_t),
        .DEPTH (IRQ_FIFO_DEPTH)
    ) irq_fifo (
        .CLOCK_50   (CLOCK_50),
        .rst_i      (rst_i),
        .push_i     (key_pop_q),
        .push_data_i(irq_push_data),
        .pop_i      (irq_pop_i),
        .pop_data_o (irq_head),
        .empty_o    (irq_empty),
        .full_o     (irq_full)
    );

    // Scancodes wait in their own FIFO while the interrupt FIFO is full.
    assign key_pending_o = !key_empty && !irq_full;
    assign irq_pending_o = !irq_empty;
    assign irq_value_o = irq_head.value;
    assign irq_vector_o = vec_table[vec_idx_t'(irq_head.irq_type)];

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_IRQ; i++)
                vec_table[i] <= '0;
        end
        else if (vec_we_i)
        begin
            vec_table[vec_idx_i] <= vec_addr_i;
        end
    end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  opcode_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    // Sums and differences wrap at 32 bits.
    always_comb
    begin
        case (op_i)
            OP_ADD:  result_o = a_i + b_i;
            OP_SUB:  result_o = a_i - b_i;
            OP_MOVI: result_o = b_i;
            default: result_o = a_i;
        endcase
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter int MEM_ADDR_BITS = 10,
    parameter int KEY_FIFO_DEPTH = 5,
    parameter int IRQ_FIFO_DEPTH = 10
)
(
    input  logic                     CLOCK_50,
    input  logic                     rst_i,
    input  logic                     run_i,
    input  logic                     load_we_i,
    input  logic [MEM_ADDR_BITS-1:0] load_addr_i,
    input  byte_t                    load_data_i,
    input  logic                     key_valid_i,
    input  byte_t                    key_code_i,
    output logic                     out_valid_o,
    output word_t                    out_data_o,
    output logic                     halted_o
);

    logic [MEM_ADDR_BITS-1:0] fetch_addr;
    byte_t fetch_data;

    reg_idx_t rd_idx_a;
    reg_idx_t rd_idx_b;
    word_t rd_data_a;
    word_t rd_data_b;
    word_t ip;
    logic wr_en;
    reg_idx_t wr_idx;
    word_t wr_data;
    logic ip_wr_en;
    word_t ip_wr_data;
    logic save;
    logic restore;

    opcode_e alu_op;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;

    logic key_enable;
    logic key_pending;
    logic key_pop;
    logic irq_pending;
    logic irq_pop;
    word_t irq_value;
    word_t irq_vector;
    logic vec_we;
    vec_idx_t vec_idx;
    word_t vec_addr;

    cpu_control #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS)
    ) u_control (
        .CLOCK_50     (CLOCK_50),
        .rst_i        (rst_i),
        .run_i        (run_i),
        .fetch_addr_o (fetch_addr),
        .fetch_data_i (fetch_data),
        .rd_idx_a_o   (rd_idx_a),
        .rd_idx_b_o   (rd_idx_b),
        .rd_data_a_i  (rd_data_a),
        .rd_data_b_i  (rd_data_b),
        .ip_i         (ip),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_data_o    (wr_data),
        .ip_wr_en_o   (ip_wr_en),
        .ip_wr_data_o (ip_wr_data),
        .save_o       (save),
        .restore_o    (restore),
        .alu_op_o     (alu_op),
        .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),
        .alu_result_i (alu_result),
        .key_enable_o (key_enable),
        .key_pending_i(key_pending),
        .key_pop_o    (key_pop),
        .irq_pending_i(irq_pending),
        .irq_pop_o    (irq_pop),
        .irq_value_i  (irq_value),
        .irq_vector_i (irq_vector),
        .vec_we_o     (vec_we),
        .vec_idx_o    (vec_idx),
        .vec_addr_o   (vec_addr),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .halted_o     (halted_o)
    );

    program_memory #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS)
    ) u_memory (
        .CLOCK_50(CLOCK_50),
        .we_i    (load_we_i),
        .waddr_i (load_addr_i),
        .wdata_i (load_data_i),
        .raddr_i (fetch_addr),
        .rdata_o (fetch_data)
    );

    register_file u_registers (
        .CLOCK_50    (CLOCK_50),
        .rst_i       (rst_i),
        .rd_idx_a_i  (rd_idx_a),
        .rd_idx_b_i  (rd_idx_b),
        .rd_data_a_o (rd_data_a),
        .rd_data_b_o (rd_data_b),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .ip_wr_en_i  (ip_wr_en),
        .ip_wr_data_i(ip_wr_data),
        .save_i      (save),
        .restore_i   (restore),
        .ip_o        (ip)
    );

    alu u_alu (
        .op_i    (alu_op),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .result_o(alu_result)
    );

    interrupt_controller #(
        .KEY_FIFO_DEPTH(KEY_FIFO_DEPTH),
        .IRQ_FIFO_DEPTH(IRQ_FIFO_DEPTH)
    ) u_interrupts (
        .CLOCK_50     (CLOCK_50),
        .rst_i        (rst_i),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .key_enable_i (key_enable),
        .key_pop_i    (key_pop),
        .key_pending_o(key_pending),
        .irq_pop_i    (irq_pop),
        .irq_pending_o(irq_pending),
        .irq_value_o  (irq_value),
        .irq_vector_o (irq_vector),
        .vec_we_i     (vec_we),
        .vec_idx_i    (vec_idx),
        .vec_addr_i   (vec_addr)
    );

endmodule

// ==== logic/program_memory.sv ====
`timescale 1ns/1ps

module program_memory
#(
    parameter int MEM_ADDR_BITS = 10
)
(
    input  logic                     CLOCK_50,
    input  logic                     we_i,
    input  logic [MEM_ADDR_BITS-1:0] waddr_i,
    input  logic [7:0]               wdata_i,
    input  logic [MEM_ADDR_BITS-1:0] raddr_i,
    output logic [7:0]               rdata_o
);

    logic [7:0] mem [2**MEM_ADDR_BITS];

    // Load port writes, fetch port reads one cycle after the address.
    always_ff @(posedge CLOCK_50)
    begin
        if (we_i)
            mem[waddr_i] <= wdata_i;
        rdata_o <= mem[raddr_i];
    end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import cpu_pkg::*;
(
    input  logic     CLOCK_50,
    input  logic     rst_i,
    input  reg_idx_t rd_idx_a_i,
    input  reg_idx_t rd_idx_b_i,
    output word_t    rd_data_a_o,
    output word_t    rd_data_b_o,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  word_t    wr_data_i,
    input  logic     ip_wr_en_i,
    input  word_t    ip_wr_data_i,
    input  logic     save_i,
    input  logic     restore_i,
    output word_t    ip_o
);

    localparam int NUM_REGS = 2**$bits(reg_idx_t);

    word_t regs [NUM_REGS];
    word_t shadow [NUM_REGS];

    assign rd_data_a_o = regs[rd_idx_a_i];
    assign rd_data_b_o = regs[rd_idx_b_i];
    assign ip_o = regs[REG_IP];

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (restore_i)
        begin
            regs <= shadow;
        end
        else
        begin
            if (wr_en_i)
                regs[wr_idx_i] <= wr_data_i;
            // The IP port wins if an instruction also targets IP.
            if (ip_wr_en_i)
                regs[REG_IP] <= ip_wr_data_i;
        end
    end

    // Shadow set takes the values from before this cycle's writes.
    always_ff @(posedge CLOCK_50)
    begin
        if (save_i)
            shadow <= regs;
    end

endmodule

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
    import cpu_pkg::*;
#(
    parameter type item_t = byte_t,
    parameter int DEPTH = 4
)
(
    input  logic  CLOCK_50,
    input  logic  rst_i,
    input  logic  push_i,
    input  item_t push_data_i,
    input  logic  pop_i,
    output item_t pop_data_o,
    output logic  empty_o,
    output logic  full_o
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    item_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic do_push;
    logic do_pop;

    // Depth need not be a power of two.
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign full_o = (count == CNT_BITS'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    always_ff @(posedge CLOCK_50)
    begin
        if (rst_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Read data stays until the next pop.
    always_ff @(posedge CLOCK_50)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
        if (do_pop)
            pop_data_o <= mem[rd_ptr];
    end

endmodule

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
(
    input logic CLOCK_50,
    input logic rst_i,
    input logic out_valid_i,
    input logic halted_i
);

    int failures = 0;

    // OUT is a one-cycle strobe.
    out_single_pulse: assert property (@(posedge CLOCK_50) disable iff (rst_i)
        out_valid_i |=> !out_valid_i)
    else
    begin
        $error("out_valid_o was high for two cycles in a row");
        failures++;
    end

    reset_clears_outputs: assert property (@(posedge CLOCK_50)
        rst_i |=> (!out_valid_i && !halted_i))
    else
    begin
        $error("out_valid_o or halted_o high after reset");
        failures++;
    end

    // Only reset leaves the halted state.
    halt_is_sticky: assert property (@(posedge CLOCK_50)
        (halted_i && !rst_i) |=> halted_i)
    else
    begin
        $error("halted_o dropped without reset");
        failures++;
    end

endmodule

bind cpu_top cpu_checker u_checker (
    .CLOCK_50   (CLOCK_50),
    .rst_i      (rst_i),
    .out_valid_i(out_valid_o),
    .halted_i   (halted_o)
);

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
    import cpu_pkg::*;
();

    localparam int MEM_ADDR_BITS = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam word_t IDX_A = 32'd1;
    localparam word_t IDX_B = 32'd2;
    localparam word_t IDX_C = 32'd3;
    localparam word_t IDX_D = 32'd4;

    logic CLOCK_50;
    logic rst_i;
    logic run_i;
    logic load_we_i;
    logic [MEM_ADDR_BITS-1:0] load_addr_i;
    byte_t load_data_i;
    logic key_valid_i;
    byte_t key_code_i;
    logic out_valid_o;
    word_t out_data_o;
    logic halted_o;

    byte_t prog_q [$];
    word_t exp_q [$];
    logic filler_en;
    word_t filler_val;
    int out_count;
    int error_count;
    int test_errors;
    int tests_passed;
    int tests_failed;
    integer seed;
    logic match_head;
    logic match_filler;
    word_t val_a;
    word_t val_b;
    word_t val_c;
    word_t val_d;
    byte_t key;

    cpu_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS),
        .KEY_FIFO_DEPTH(5),
        .IRQ_FIFO_DEPTH(10)
    ) uut (
        .CLOCK_50   (CLOCK_50),
        .rst_i      (rst_i),
        .run_i      (run_i),
        .load_we_i  (load_we_i),
        .load_addr_i(load_addr_i),
        .load_data_i(load_data_i),
        .key_valid_i(key_valid_i),
        .key_code_i (key_code_i),
        .out_valid_o(out_valid_o),
        .out_data_o (out_data_o),
        .halted_o   (halted_o)
    );

    initial
    begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // Each OUT pulse matches the oldest expected value, or the loop's filler value.
    always @(negedge CLOCK_50)
    begin
        if (out_valid_o)
        begin
            out_count = out_count + 1;
            match_head = (exp_q.size() > 0) && (out_data_o == exp_q[0]);
            match_filler = filler_en && (out_data_o == filler_val);
            assert (match_head || match_filler)
            else
            begin
                if (exp_q.size() > 0)
                    $display("ERROR out_data_o expected %h actual %h", exp_q[0], out_data_o);
                else
                    $display("Unexpected OUT pulse with value %h.", out_data_o);
                error_count = error_count + 1;
            end
            if (match_head)
                void'(exp_q.pop_front());
        end
    end

    task automatic apply_reset();
        @(posedge CLOCK_50);
        #1;
        rst_i = 1'b1;
        run_i = 1'b0;
        key_valid_i = 1'b0;
        repeat (3) @(posedge CLOCK_50);
        #1;
        rst_i = 1'b0;
    endtask

    task automatic start_test();
        apply_reset();
        filler_en = 1'b0;
        out_count = 0;
        prog_q.delete();
        exp_q.delete();
        test_errors = error_count;
    endtask

    // Opcode, then operand1 and operand2, each low byte first.
    task automatic emit(input opcode_e op, input word_t op1, input word_t op2);
        prog_q.push_back(byte_t'(op));
        for (int i = 0; i < OPERAND_BYTES; i++)
            prog_q.push_back(op1[8*i +: 8]);
        for (int i = 0; i < OPERAND_BYTES; i++)
            prog_q.push_back(op2[8*i +: 8]);
    endtask

    task automatic load_and_run();
        for (int i = 0; i < prog_q.size(); i++)
        begin
            @(posedge CLOCK_50);
            #1;
            load_we_i = 1'b1;
            load_addr_i = MEM_ADDR_BITS'(i);
            load_data_i = prog_q[i];
        end
        @(posedge CLOCK_50);
        #1;
        load_we_i = 1'b0;
        run_i = 1'b1;
    endtask

    task automatic press_key(input byte_t code);
        @(posedge CLOCK_50);
        #1;
        key_valid_i = 1'b1;
        key_code_i = code;
        @(posedge CLOCK_50);
        #1;
        key_valid_i = 1'b0;
    endtask

    task automatic wait_outputs(input int n);
        int cycles;
        cycles = 0;
        while ((out_count < n) && (cycles < TIMEOUT_CYCLES))
        begin
            @(posedge CLOCK_50);
            cycles = cycles + 1;
        end
        if (out_count < n)
        begin
            $display("Timed out waiting for %0d OUT pulses.", n);
            error_count = error_count + 1;
        end
    endtask

    task automatic drain_expected();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0) && (cycles < TIMEOUT_CYCLES))
        begin
            @(posedge CLOCK_50);
            cycles = cycles + 1;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timed out with %0d expected OUT values missing.", exp_q.size());
            error_count = error_count + 1;
        end
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted_o && (cycles < TIMEOUT_CYCLES))
        begin
            @(negedge CLOCK_50);
            cycles = cycles + 1;
        end
        if (!halted_o)
        begin
            $display("Timed out waiting for the processor to halt.");
            error_count = error_count + 1;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (error_count == test_errors)
        begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: pass", num, name);
        end
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: fail", num, name);
        end
    endtask

    initial
    begin
        rst_i = 1'b1;
        run_i = 1'b0;
        load_we_i = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        key_valid_i = 1'b0;
        key_code_i = '0;
        filler_en = 1'b0;
        filler_val = '0;
        out_count = 0;
        error_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed = 32'hdeb4_c41b;

        // MOVI then OUT of A and B.
        start_test();
        val_a = $random(seed);
        val_b = $random(seed);
        emit(OP_MOVI, IDX_A, val_a);
        emit(OP_MOVI, IDX_B, val_b);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_HALT, 32'd0, 32'd0);
        exp_q.push_back(val_a);
        exp_q.push_back(val_b);
        load_and_run();
        drain_expected();
        wait_halted();
        finish_test(1, "movi and out");

        // Operands chosen so that both results wrap past 2**32 once.
        start_test();
        val_a = $random(seed) | 32'h8000_0000;
        val_b = $random(seed) | 32'h8000_0000;
        val_c = $random(seed) & 32'h7fff_ffff;
        val_d = $random(seed) | 32'h8000_0000;
        emit(OP_MOVI, IDX_A, val_a);
        emit(OP_MOVI, IDX_B, val_b);
        emit(OP_ADD, IDX_A, IDX_B);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_MOVI, IDX_C, val_c);
        emit(OP_MOVI, IDX_D, val_d);
        emit(OP_SUB, IDX_C, IDX_D);
        emit(OP_OUT, IDX_C, 32'd0);
        emit(OP_HALT, 32'd0, 32'd0);
        exp_q.push_back(word_t'({1'b0, val_a} + {1'b0, val_b} - 33'h1_0000_0000));
        exp_q.push_back(word_t'(33'h1_0000_0000 + {1'b0, val_c} - {1'b0, val_d}));
        load_and_run();
        drain_expected();
        wait_halted();
        finish_test(2, "add and sub");

        // JMP at 18 skips the OUT A at 27.
        start_test();
        val_a = $random(seed);
        val_b = ~val_a;
        emit(OP_MOVI, IDX_A, val_a);
        emit(OP_MOVI, IDX_B, val_b);
        emit(OP_JMP, 32'd0, 32'd36);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_HALT, 32'd0, 32'd0);
        exp_q.push_back(val_b);
        load_and_run();
        drain_expected();
        wait_halted();
        finish_test(3, "jump");

        // Main loop at 27 prints B, the ISR at 45 prints A and clobbers B.
        start_test();
        val_b = $random(seed) | 32'h0100_0000;
        key = byte_t'($random(seed));
        emit(OP_SETIV, 32'd0, 32'd45);
        emit(OP_MOVI, IDX_B, val_b);
        emit(OP_EI, 32'd0, 32'd0);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_JMP, 32'd0, 32'd27);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_MOVI, IDX_B, ~val_b);
        emit(OP_IRET, 32'd0, 32'd0);
        filler_en = 1'b1;
        filler_val = val_b;
        load_and_run();
        wait_outputs(2);
        exp_q.push_back({24'h0, key});
        exp_q.push_back(val_b);
        exp_q.push_back(val_b);
        press_key(key);
        drain_expected();
        finish_test(4, "keyboard interrupt");

        // The key arrives before EI executes and is dropped.
        start_test();
        val_b = $random(seed) | 32'h0100_0000;
        key = byte_t'($random(seed));
        emit(OP_SETIV, 32'd0, 32'd63);
        emit(OP_MOVI, IDX_B, val_b);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_EI, 32'd0, 32'd0);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_OUT, IDX_B, 32'd0);
        emit(OP_HALT, 32'd0, 32'd0);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_IRET, 32'd0, 32'd0);
        exp_q.push_back(val_b);
        exp_q.push_back(val_b);
        exp_q.push_back(val_b);
        load_and_run();
        wait_outputs(1);
        press_key(key);
        wait_halted();
        drain_expected();
        finish_test(5, "key before enable");

        // Nothing may follow HALT, and reset clears the outputs.
        start_test();
        val_a = $random(seed);
        emit(OP_MOVI, IDX_A, val_a);
        emit(OP_OUT, IDX_A, 32'd0);
        emit(OP_HALT, 32'd0, 32'd0);
        emit(OP_OUT, IDX_A, 32'd0);
        exp_q.push_back(val_a);
        load_and_run();
        wait_halted();
        drain_expected();
        repeat (50) @(posedge CLOCK_50);
        apply_reset();
        @(negedge CLOCK_50);
        assert (halted_o == 1'b0)
        else
        begin
            $display("ERROR halted_o expected 0 actual %h", halted_o);
            error_count = error_count + 1;
        end
        assert (out_valid_o == 1'b0)
        else
        begin
            $display("ERROR out_valid_o expected 0 actual %h", out_valid_o);
            error_count = error_count + 1;
        end
        finish_test(6, "halt and reset");

        error_count = error_count + uut.u_checker.failures;
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if ((tests_failed == 0) && (error_count == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
